// File: source/mmu_pkg.sv
//----------------------------
// Page geometry, page and map entry types,
// arbiter write-class opcodes
//----------------------------
`default_nettype none

package mmu_pkg;

    //----------------------------
    // Page geometry
    //----------------------------
    localparam int PAGE_BITS       = 10;    // Page number width
    localparam int OFFSET_BITS     = 10;    // Word offset within a page
    localparam int NUM_PAGES       = 1024;  // Map and bit memory depth
    localparam int BESM6_PAGE_BITS = 5;     // Virtual page width in BESM-6 mode
    localparam int MAP_BITS        = 20;    // Page map entry width

    //----------------------------
    // Types
    //----------------------------
    typedef logic [PAGE_BITS-1:0]             page_t;       // Page number
    typedef logic [PAGE_BITS+OFFSET_BITS-1:0] phys_addr_t;  // Page and offset
    typedef logic [MAP_BITS-1:0]              map_entry_t;  // Physical page in 19..10
    typedef logic [3:0]                       arb_op_t;     // Arbiter opcode

    //----------------------------
    // Write-class arbiter opcodes
    //----------------------------
    localparam arb_op_t ARB_CCWR  = 4'd2;   // Instruction cache write
    localparam arb_op_t ARB_DCWR  = 4'd4;   // Operand cache write
    localparam arb_op_t ARB_DWR   = 4'd10;  // Result write
    localparam arb_op_t ARB_RDMWR = 4'd11;  // Read-modify-write
    localparam arb_op_t ARB_BTRWR = 4'd12;  // Block transfer write

endpackage

`default_nettype wire

// File: source/page_bus_if.sv
//----------------------------
// Request and page index bundle between
// translator and page-state modules
//----------------------------
`timescale 1ns/10ps
`default_nettype none

interface page_bus_if;
    import mmu_pkg::*;

    logic  req;             // Bus request strobe
    page_t trans_page;      // Translated page of the request
    logic  req_write;       // Request is write-class
    page_t pg_index;        // Physical page index register

    // Translator side
    modport translator (
        output req,
        output trans_page,
        output req_write
    );

    // Index register and used/dirty bits
    modport status (
        input  req,
        input  trans_page,
        input  req_write,
        output pg_index
    );

    // Reprioritize memory only follows the index
    modport reprio (
        input  pg_index
    );

endinterface

`default_nettype wire

// File: source/page_translator.sv
//----------------------------
// Page map memory, virtual page select,
// address translation and write-class decode
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module page_translator (
    input  wire                     clk,            // Clock
    input  wire mmu_pkg::phys_addr_t i_vaddr,       // Virtual address
    input  wire                     i_besm6,        // BESM-6 emulation mode
    input  wire                     i_no_paging,    // Paging blocked
    input  wire                     i_map_wr,       // Map write strobe
    input  wire mmu_pkg::page_t     i_map_vpage,    // Map entry being written
    input  wire mmu_pkg::map_entry_t i_map_entry,   // New map entry
    input  wire                     i_req,          // Bus request strobe
    input  wire mmu_pkg::arb_op_t   i_arb_op,       // Arbiter opcode of request
    output mmu_pkg::phys_addr_t     o_physad,       // Translated address
    output mmu_pkg::page_t          o_trans_page,   // Translated page
    page_bus_if.translator          bus             // To page-state modules
);
    import mmu_pkg::*;

    map_entry_t map_mem [NUM_PAGES];    // Page map memory, no reset
    map_entry_t map_rd;                 // Entry of current virtual page
    page_t      vpage;                  // Selected virtual page
    page_t      ppage;                  // Physical page after translation
    logic       is_write;               // Write-class opcode

    //----------------------------
    // Map memory write
    //----------------------------
    always_ff @(posedge clk) begin
        if (i_map_wr)
            map_mem[i_map_vpage] <= i_map_entry;    // Visible from next cycle
    end

    //----------------------------
    // Virtual page and translation
    //----------------------------
    always_comb begin
        if (i_besm6)
            vpage = {{(PAGE_BITS-BESM6_PAGE_BITS){1'b0}},
                     i_vaddr[OFFSET_BITS +: BESM6_PAGE_BITS]};  // 15-bit address space
        else
            vpage = i_vaddr[OFFSET_BITS +: PAGE_BITS];          // 20-bit address space
    end

    assign map_rd = map_mem[vpage];     // Asynchronous map read

    always_comb begin
        if (i_no_paging)
            ppage = vpage;                              // Identity mapping
        else
            ppage = map_rd[MAP_BITS-1 -: PAGE_BITS];    // Upper bits hold physical page
    end

    assign o_physad     = {ppage, i_vaddr[OFFSET_BITS-1:0]};    // Page joined with offset
    assign o_trans_page = ppage;

    //----------------------------
    // Write-class decode
    //----------------------------
    always_comb begin
        case (i_arb_op)
            ARB_CCWR, ARB_DCWR, ARB_DWR, ARB_RDMWR, ARB_BTRWR: is_write = 1'b1;
            default: is_write = 1'b0;   // Reads and control ops
        endcase
    end

    // Request forwarded with its page
    assign bus.req        = i_req;
    assign bus.trans_page = ppage;
    assign bus.req_write  = is_write;

    // Dirty marking depends on a clean opcode
    a_arb_op_known: assert property (
        @(posedge clk) i_req |-> !$isunknown(i_arb_op)
    ) else $error("Arbiter opcode unknown during request");

endmodule

`default_nettype wire

// File: source/page_status.sv
//----------------------------
// Physical page index register and
// per-page used and dirty bits
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module page_status (
    input  wire                 clk,            // Clock
    input  wire                 reset,          // Synchronous reset
    input  wire                 i_index_wr,     // Direct index load
    input  wire mmu_pkg::page_t i_index,        // New index value
    input  wire                 i_acc_wr,       // Direct used/dirty write
    input  wire                 i_acc_used,     // Used bit to write
    input  wire                 i_acc_dirty,    // Dirty bit to write
    output logic                o_used,         // Used bit at index
    output logic                o_dirty,        // Dirty bit at index
    page_bus_if.status          bus             // Request in, index out
);
    import mmu_pkg::*;

    logic  used_mem  [NUM_PAGES];   // Page referenced
    logic  dirty_mem [NUM_PAGES];   // Page modified
    page_t pg_index;                // Physical page index register

    //----------------------------
    // Index register
    //----------------------------
    always_ff @(posedge clk) begin
        if (reset)
            pg_index <= '0;
        else if (bus.req)
            pg_index <= bus.trans_page;     // Request has priority
        else if (i_index_wr)
            pg_index <= i_index;            // Direct load
    end

    //----------------------------
    // Used and dirty bits
    //----------------------------
    always_ff @(posedge clk) begin
        if (bus.req) begin
            used_mem[bus.trans_page] <= 1'b1;           // Any access marks used
            if (bus.req_write)
                dirty_mem[bus.trans_page] <= 1'b1;      // Writes mark dirty
        end else if (i_acc_wr) begin
            used_mem[pg_index]  <= i_acc_used;          // Software bookkeeping
            dirty_mem[pg_index] <= i_acc_dirty;
        end
    end

    // Reads follow the index register
    assign o_used       = used_mem[pg_index];
    assign o_dirty      = dirty_mem[pg_index];
    assign bus.pg_index = pg_index;

    //----------------------------
    // Checks
    //----------------------------
    // Index is never X once reset has been applied
    a_index_known: assert property (
        @(posedge clk) !reset |-> !$isunknown(pg_index)
    ) else $error("Page index unknown after reset");

    // Write request from translator shows up as dirty
    a_write_marks_dirty: assert property (
        @(posedge clk) disable iff (reset)
        (bus.req && bus.req_write) |=> dirty_mem[$past(bus.trans_page)]
    ) else $error("Write request did not mark page dirty");

endmodule

`default_nettype wire

// File: source/reprio_fill.sv
//----------------------------
// Reprioritize bit memory and fill
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module reprio_fill (
    input  wire         clk,            // Clock
    input  wire         reset,          // Synchronous reset
    input  wire         i_reprio_wr,    // Write reprio bit at index
    input  wire         i_reprio_bit,   // Bit value to write
    input  wire         i_fill_start,   // Start fill from index
    output logic        o_reprio,       // Reprio bit at index
    output logic        o_fill_busy,    // Fill in progress
    page_bus_if.reprio  bus             // Current page index
);
    import mmu_pkg::*;

    logic  reprio_mem [NUM_PAGES];  // Reprioritize request per page
    logic  fill_busy;               // Fill running
    page_t fill_cnt;                // Page written this cycle

    //----------------------------
    // Fill sequencer
    //----------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
            fill_cnt  <= '0;
        end else if (fill_busy) begin
            if (fill_cnt == page_t'(NUM_PAGES - 1))
                fill_busy <= 1'b0;              // Last page done
            else
                fill_cnt <= fill_cnt + 1'b1;    // Next page up
        end else if (i_fill_start) begin
            fill_busy <= 1'b1;                  // Start ignored while busy
            fill_cnt  <= bus.pg_index;          // Begin at current index
        end
    end

    //----------------------------
    // Bit memory
    //----------------------------
    always_ff @(posedge clk) begin
        if (fill_busy)
            reprio_mem[fill_cnt] <= 1'b1;               // Fill owns the memory
        else if (i_reprio_wr)
            reprio_mem[bus.pg_index] <= i_reprio_bit;
    end

    assign o_reprio    = reprio_mem[bus.pg_index];
    assign o_fill_busy = fill_busy;

    //----------------------------
    // Checks
    //----------------------------
    // Counter climbs without wrapping while busy
    a_fill_no_wrap: assert property (
        @(posedge clk) disable iff (reset)
        (fill_busy && fill_cnt != page_t'(NUM_PAGES - 1)) |=>
            fill_busy && fill_cnt == $past(fill_cnt) + 1'b1
    ) else $error("Fill counter skipped or wrapped");

    // Busy drops only after the last page
    a_fill_end: assert property (
        @(posedge clk) disable iff (reset)
        ($fell(fill_busy) && !$past(reset)) |->
            $past(fill_cnt) == page_t'(NUM_PAGES - 1)
    ) else $error("Fill ended before last page");

endmodule

`default_nettype wire

// File: source/mmu_top.sv
//----------------------------
// MMU top with translator, page status
// and reprioritize fill
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module mmu_top (
    input  wire                      clk,           // Clock
    input  wire                      reset,         // Synchronous reset
    // Translation
    input  wire mmu_pkg::phys_addr_t i_vaddr,       // Virtual address
    input  wire                      i_besm6,       // BESM-6 emulation mode
    input  wire                      i_no_paging,   // Paging blocked
    // Page map write
    input  wire                      i_map_wr,      // Map write strobe
    input  wire mmu_pkg::page_t      i_map_vpage,   // Virtual page to remap
    input  wire mmu_pkg::map_entry_t i_map_entry,   // New map entry
    // Bus request
    input  wire                      i_req,         // Request strobe
    input  wire mmu_pkg::arb_op_t    i_arb_op,      // Arbiter opcode
    // Direct index and bit access
    input  wire                      i_index_wr,    // Load index
    input  wire mmu_pkg::page_t      i_index,       // Index value
    input  wire                      i_acc_wr,      // Write used/dirty
    input  wire                      i_acc_used,    // Used bit value
    input  wire                      i_acc_dirty,   // Dirty bit value
    // Reprioritize bits
    input  wire                      i_reprio_wr,   // Write reprio bit
    input  wire                      i_reprio_bit,  // Reprio bit value
    input  wire                      i_fill_start,  // Start fill with ones
    // Results
    output mmu_pkg::phys_addr_t      o_physad,      // Physical address
    output mmu_pkg::page_t           o_trans_page,  // Translated page
    output mmu_pkg::page_t           o_pg_index,    // Index register
    output logic                     o_used,        // Used bit at index
    output logic                     o_dirty,       // Dirty bit at index
    output logic                     o_reprio,      // Reprio bit at index
    output logic                     o_fill_busy    // Fill running
);

    page_bus_if pbus ();    // Request and index bundle

    //----------------------------
    // Translation
    //----------------------------
    page_translator u_translator (
        .clk          (clk),
        .i_vaddr      (i_vaddr),
        .i_besm6      (i_besm6),
        .i_no_paging  (i_no_paging),
        .i_map_wr     (i_map_wr),
        .i_map_vpage  (i_map_vpage),
        .i_map_entry  (i_map_entry),
        .i_req        (i_req),
        .i_arb_op     (i_arb_op),
        .o_physad     (o_physad),
        .o_trans_page (o_trans_page),
        .bus          (pbus.translator)
    );

    //----------------------------
    // Index and used/dirty bits
    //----------------------------
    page_status u_status (
        .clk         (clk),
        .reset       (reset),
        .i_index_wr  (i_index_wr),
        .i_index     (i_index),
        .i_acc_wr    (i_acc_wr),
        .i_acc_used  (i_acc_used),
        .i_acc_dirty (i_acc_dirty),
        .o_used      (o_used),
        .o_dirty     (o_dirty),
        .bus         (pbus.status)
    );

    //----------------------------
    // Reprioritize memory
    //----------------------------
    reprio_fill u_reprio (
        .clk          (clk),
        .reset        (reset),
        .i_reprio_wr  (i_reprio_wr),
        .i_reprio_bit (i_reprio_bit),
        .i_fill_start (i_fill_start),
        .o_reprio     (o_reprio),
        .o_fill_busy  (o_fill_busy),
        .bus          (pbus.reprio)
    );

    assign o_pg_index = pbus.pg_index;  // Index seen by software

endmodule

`default_nettype wire

// File: test/mmu_tb.sv
//----------------------------
// MMU testbench: reference model, checking
// assertions, directed and random stimulus
//----------------------------
`timescale 1ns/10ps
`default_nettype none

module mmu_tb;
    import mmu_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;   // Worst-case fill plus directed phases

    logic       clk, reset;
    phys_addr_t i_vaddr;
    logic       i_besm6, i_no_paging, i_map_wr, i_req, i_index_wr;
    page_t      i_map_vpage, i_index;
    map_entry_t i_map_entry;
    arb_op_t    i_arb_op;
    logic       i_acc_wr, i_acc_used, i_acc_dirty, i_reprio_wr, i_reprio_bit, i_fill_start;
    phys_addr_t o_physad;
    page_t      o_trans_page, o_pg_index;
    logic       o_used, o_dirty, o_reprio, o_fill_busy;

    //----------------------------
    // Reference model state
    //----------------------------
    map_entry_t map_m    [NUM_PAGES];   // Unwritten entries stay X like the DUT
    logic       used_m   [NUM_PAGES];
    logic       dirty_m  [NUM_PAGES];
    logic       reprio_m [NUM_PAGES];
    page_t      idx_m;                  // Index register
    logic       busy_m;                 // Fill running
    page_t      fill_m;                 // Page filled this cycle
    page_t      vpage_m, exp_page;
    map_entry_t pick_m;
    phys_addr_t exp_physad;
    page_t      mapped_q [$];           // Virtual pages with a known entry
    integer     seed;
    int         cycles = 0;

    mmu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;         // 40 ns period
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Opcodes 2, 4, 10, 11, 12 are writes
    function automatic logic write_class(input arb_op_t op);
        return (op == 4'd2) || (op == 4'd4) || (op == 4'd10) || (op == 4'd11) || (op == 4'd12);
    endfunction

    // Expected translation from the model map
    assign vpage_m    = i_besm6 ? page_t'(i_vaddr[14:10]) : i_vaddr[19:10];
    assign pick_m     = map_m[vpage_m];
    assign exp_page   = i_no_paging ? vpage_m : pick_m[19:10];  // Physical page in upper bits
    assign exp_physad = {exp_page, i_vaddr[9:0]};

    always @(posedge clk) begin
        if (reset) begin
            idx_m  <= '0;
            busy_m <= 1'b0;
        end else begin
            if (i_req) begin                            // Request wins over direct writes
                idx_m            <= exp_page;
                used_m[exp_page] <= 1'b1;
                if (write_class(i_arb_op))
                    dirty_m[exp_page] <= 1'b1;
            end else begin
                if (i_index_wr)
                    idx_m <= i_index;
                if (i_acc_wr) begin
                    used_m[idx_m]  <= i_acc_used;
                    dirty_m[idx_m] <= i_acc_dirty;
                end
            end
            if (busy_m) begin                           // Ones from start page upward
                reprio_m[fill_m] <= 1'b1;
                if (fill_m == page_t'(NUM_PAGES - 1))
                    busy_m <= 1'b0;
                else
                    fill_m <= fill_m + 1'b1;
            end else begin
                if (i_fill_start) begin
                    busy_m <= 1'b1;
                    fill_m <= idx_m;
                end
                if (i_reprio_wr)
                    reprio_m[idx_m] <= i_reprio_bit;
            end
        end
        if (i_map_wr)
            map_m[i_map_vpage] <= i_map_entry;
    end

    //----------------------------
    // Checking assertions
    //----------------------------
    a_physad: assert property (@(posedge clk) disable iff (reset) o_physad === exp_physad)
        else stop_on_error($sformatf("ERROR %0t ns: o_physad %h, expected %h",
                           $time, $sampled(o_physad), $sampled(exp_physad)));
    a_trans_page: assert property (@(posedge clk) disable iff (reset) o_trans_page === exp_page)
        else stop_on_error($sformatf("ERROR %0t ns: o_trans_page wrong", $time));
    a_index: assert property (@(posedge clk) disable iff (reset) o_pg_index === idx_m)
        else stop_on_error($sformatf("ERROR %0t ns: o_pg_index %h, expected %h",
                           $time, $sampled(o_pg_index), $sampled(idx_m)));
    a_used: assert property (@(posedge clk) disable iff (reset) o_used === used_m[idx_m])
        else stop_on_error($sformatf("ERROR %0t ns: o_used does not match model", $time));
    a_dirty: assert property (@(posedge clk) disable iff (reset) o_dirty === dirty_m[idx_m])
        else stop_on_error($sformatf("ERROR %0t ns: o_dirty does not match model", $time));
    a_reprio: assert property (@(posedge clk) disable iff (reset) o_reprio === reprio_m[idx_m])
        else stop_on_error($sformatf("ERROR %0t ns: o_reprio does not match model", $time));
    a_busy: assert property (@(posedge clk) disable iff (reset) o_fill_busy === busy_m)
        else stop_on_error($sformatf("ERROR %0t ns: o_fill_busy does not match model", $time));
    a_req_result: assert property (@(posedge clk) disable iff (reset)
        i_req |=> (o_used === 1'b1 && o_pg_index === $past(exp_page)))
        else stop_on_error($sformatf("ERROR %0t ns: request not reflected in index", $time));
    a_req_dirty: assert property (@(posedge clk) disable iff (reset)
        (i_req && write_class(i_arb_op)) |=> o_dirty === 1'b1)
        else stop_on_error($sformatf("ERROR %0t ns: write request left page clean", $time));
    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> (o_fill_busy === 1'b0 && o_pg_index === '0))
        else stop_on_error($sformatf("ERROR %0t ns: wrong state after reset", $time));

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            stop_on_error("Timeout: the run did not finish within the cycle limit");
    end

    //----------------------------
    // Stimulus tasks
    //----------------------------
    task automatic step;                // Inputs change 2 ns after the edge
        @(posedge clk);
        #2;
    endtask

    task automatic write_map(input page_t vp, input map_entry_t e);
        i_map_wr    = 1'b1;
        i_map_vpage = vp;
        i_map_entry = e;
        step();
        i_map_wr    = 1'b0;
    endtask

    // Mode 0 normal on a mapped page, 1 BESM-6, 2 paging blocked
    task automatic set_mode_addr(input int mode);
        phys_addr_t va;
        va = $random(seed);
        if (mode == 0)
            va[19:10] = mapped_q[$unsigned($random(seed)) % mapped_q.size()];
        i_vaddr     = va;
        i_besm6     = (mode == 1);
        i_no_paging = (mode == 2);
    endtask

    task automatic load_index(input page_t p);
        i_index_wr = 1'b1;
        i_index    = p;
        step();
        i_index_wr = 1'b0;
    endtask

    task automatic run_fill(input page_t start, output int n);
        load_index(start);
        i_fill_start = 1'b1;
        step();
        i_fill_start = 1'b0;
        n = 0;
        while (o_fill_busy === 1'b1) begin
            n++;
            i_reprio_wr = 1'b0;
            if (n == 10) begin
                i_fill_start = 1'b1;                // Second start, ignored
            end else if (n == 11) begin
                i_fill_start = 1'b0;
                i_index_wr   = 1'b1;                // Move to a page below the fill
                i_index      = start - 2'd1;
            end else if (n == 12) begin
                i_index_wr   = 1'b0;
                i_reprio_wr  = 1'b1;                // Write of 0, ignored while busy
                i_reprio_bit = 1'b0;
            end
            step();
        end
        i_reprio_wr = 1'b0;
    endtask

    task automatic check_filled(input page_t p);
        load_index(p);
        assert (o_reprio === 1'b1)
            else stop_on_error($sformatf("ERROR %0t ns: page %0d not filled", $time, p));
    endtask

    //----------------------------
    // Test sequence
    //----------------------------
    initial begin
        int    k;
        int    s;
        int    n;
        page_t vp;
        seed = 32'he183;
        reset = 1'b1;
        {i_vaddr, i_besm6, i_no_paging, i_map_wr, i_map_vpage, i_map_entry} = '0;
        {i_req, i_arb_op, i_index_wr, i_index, i_acc_wr, i_acc_used, i_acc_dirty} = '0;
        {i_reprio_wr, i_reprio_bit, i_fill_start} = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        for (k = 0; k < 32; k++) begin          // Whole BESM-6 page range
            write_map(page_t'(k), $random(seed));
            mapped_q.push_back(page_t'(k));
        end
        for (k = 0; k < 16; k++) begin          // Scattered normal-mode pages
            vp = $random(seed);
            write_map(vp, $random(seed));
            mapped_q.push_back(vp);
        end
        for (k = 0; k < 60; k++) begin          // Translation in all modes
            set_mode_addr(k % 3);
            step();
        end
        for (k = 0; k < 40; k++) begin          // Requests with random opcodes
            set_mode_addr($unsigned($random(seed)) % 3);
            i_req    = 1'b1;
            i_arb_op = $random(seed);
            step();
            i_req    = 1'b0;
        end
        for (k = 0; k < 8; k++) begin           // Direct index and access writes
            load_index($random(seed));
            i_acc_wr    = 1'b1;
            i_acc_used  = $random(seed);
            i_acc_dirty = $random(seed);
            step();
            i_acc_wr    = 1'b0;
            step();
        end
        vp = idx_m;                             // Page whose bits must survive
        set_mode_addr(2);                       // Request beats index and access writes
        i_req       = 1'b1;
        i_arb_op    = 4'd0;
        i_index_wr  = 1'b1;
        i_index     = $random(seed);
        i_acc_wr    = 1'b1;
        i_acc_used  = ~used_m[vp];              // Opposite of the stored bits
        i_acc_dirty = ~dirty_m[vp];
        step();
        {i_req, i_index_wr, i_acc_wr} = '0;
        load_index(vp);                         // Stored bits read back unchanged
        for (k = 0; k < 8; k++) begin           // Reprioritize writes
            load_index($random(seed));
            i_reprio_wr  = 1'b1;
            i_reprio_bit = $random(seed);
            step();
            i_reprio_wr  = 1'b0;
            step();
        end
        s = 100 + ($unsigned($random(seed)) % 800);
        load_index(s - 1);                      // Marks below the fill start
        i_reprio_wr  = 1'b1;
        i_reprio_bit = 1'b1;
        step();
        load_index(s - 2);
        i_reprio_bit = 1'b0;
        step();
        i_reprio_wr  = 1'b0;
        run_fill(s, n);
        assert (n == NUM_PAGES - s)
            else stop_on_error($sformatf("ERROR %0t ns: fill busy %0d cycles, expected %0d",
                               $time, n, NUM_PAGES - s));
        check_filled(s);
        check_filled(s + 1);
        check_filled(NUM_PAGES - 1);
        for (k = 0; k < 8; k++)
            check_filled(s + ($unsigned($random(seed)) % (NUM_PAGES - s)));
        load_index(s - 1);                      // Model holds 1 here
        load_index(s - 2);                      // Model holds 0 here
        run_fill(NUM_PAGES - 1, n);             // Single-page fill
        assert (n == 1)
            else stop_on_error($sformatf("ERROR %0t ns: last-page fill busy %0d cycles",
                               $time, n));
        step();
        step();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: besm_mmu.f
source/mmu_pkg.sv
source/page_bus_if.sv
source/page_translator.sv
source/page_status.sv
source/reprio_fill.sv
source/mmu_top.sv
test/mmu_tb.sv
